// ==== logic/eth_fcs_pkg.sv ====
package eth_fcs_pkg;

    // one 64-bit stream beat, byte lanes enabled from keep[0] upward
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } axis_beat_t;

    typedef logic [31:0] crc_t;

    // ethernet crc-32, reflected form of 0x04c11db7
    localparam crc_t CRC_POLY_REFL = 32'hedb8_8320;

    localparam crc_t CRC_INIT = 32'hffff_ffff;

    // register value once a good frame and its fcs are shifted in
    localparam crc_t CRC_RESIDUE = 32'hdebb_20e3;

    // width of each status count field
    localparam int STATUS_COUNT_W = 16;

    typedef struct packed {
        logic [STATUS_COUNT_W-1:0] frame_count;
        logic [STATUS_COUNT_W-1:0] bad_fcs_count;
    } fcs_status_t;

endpackage

// ==== logic/crc32_step.sv ====
`timescale 1ns/1ps

module crc32_step #(
    parameter int DATA_BYTES = 8
) (
    input  logic [DATA_BYTES*8-1:0] data,
    input  eth_fcs_pkg::crc_t       state_in,
    output eth_fcs_pkg::crc_t       state_out
);
    import eth_fcs_pkg::*;

    crc_t crc;

    // byte 0 goes in first, each byte lsb first
    always_comb begin
        crc = state_in;
        for (int b = 0; b < DATA_BYTES; b++) begin
            crc[7:0] = crc[7:0] ^ data[b*8 +: 8];
            for (int i = 0; i < 8; i++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ CRC_POLY_REFL;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
    end

    assign state_out = crc;

endmodule

// ==== logic/axis_skid_buffer.sv ====
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_fcs_pkg::axis_beat_t int_beat,
    input  logic                    int_valid,
    output logic                    int_ready,
    output logic                    int_ready_early,
    output eth_fcs_pkg::axis_beat_t out_beat,
    output logic                    out_valid,
    input  logic                    out_ready
);
    import eth_fcs_pkg::*;

    axis_beat_t temp_beat;
    logic       temp_valid;
    logic       out_valid_next;
    logic       temp_valid_next;
    logic       store_int_to_out;
    logic       store_int_to_temp;
    logic       store_temp_to_out;

    // ready next cycle if the sink drains or temp cannot fill
    assign int_ready_early = out_ready || (!temp_valid && (!out_valid || !int_valid));

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        store_int_to_out = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;
        if (int_ready) begin
            if (out_ready || !out_valid) begin
                out_valid_next = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // output stalled, beat in flight parks in temp
                temp_valid_next = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            int_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            int_ready <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_beat <= int_beat;
        end else if (store_temp_to_out) begin
            out_beat <= temp_beat;
        end
        if (store_int_to_temp) begin
            temp_beat <= int_beat;
        end
    end

endmodule

// ==== logic/fcs_check_core.sv ====
`timescale 1ns/1ps

module fcs_check_core (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_fcs_pkg::axis_beat_t in_beat,
    input  logic                    in_valid,
    output logic                    in_ready,
    output eth_fcs_pkg::axis_beat_t int_beat,
    output logic                    int_valid,
    input  logic                    int_ready,
    input  logic                    int_ready_early,
    output logic                    busy,
    output logic                    bad_fcs
);
    import eth_fcs_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PAYLOAD,
        ST_TAIL
    } state_t;

    state_t      state;
    state_t      state_next;
    logic        in_ready_next;
    logic        bad_fcs_next;
    logic        in_fire;
    logic        tail;

    crc_t        crc_state;
    crc_t        crc_state4;
    crc_t        crc_base;
    crc_t        crc_next1;
    crc_t        crc_next2;
    crc_t        crc_next3;
    crc_t        crc_next4;
    crc_t        crc_next8;
    logic        crc_reset;
    logic        crc_update;
    logic        crc_match;
    logic [31:0] check_data;
    logic [3:0]  check_keep;

    axis_beat_t  d0_beat;
    logic        d0_valid;
    logic        d0_load;
    logic        d0_clear;
    logic [7:0]  tail_keep;
    logic        tail_user;
    logic        tail_load;

    assign in_fire = in_valid && in_ready;
    assign tail = (state == ST_TAIL);

    // tail cycle resumes from the 4-byte point of the held beat
    assign crc_base = tail ? crc_state4 : crc_state;
    assign check_data = tail ? d0_beat.data[63:32] : in_beat.data[31:0];
    assign check_keep = tail ? d0_beat.keep[7:4] : in_beat.keep[3:0];

    crc32_step #(.DATA_BYTES(1)) u_crc1 (
        .data      (check_data[7:0]),
        .state_in  (crc_base),
        .state_out (crc_next1)
    );

    crc32_step #(.DATA_BYTES(2)) u_crc2 (
        .data      (check_data[15:0]),
        .state_in  (crc_base),
        .state_out (crc_next2)
    );

    crc32_step #(.DATA_BYTES(3)) u_crc3 (
        .data      (check_data[23:0]),
        .state_in  (crc_base),
        .state_out (crc_next3)
    );

    crc32_step #(.DATA_BYTES(4)) u_crc4 (
        .data      (check_data),
        .state_in  (crc_base),
        .state_out (crc_next4)
    );

    crc32_step #(.DATA_BYTES(8)) u_crc8 (
        .data      (in_beat.data),
        .state_in  (crc_state),
        .state_out (crc_next8)
    );

    always_comb begin
        case (check_keep)
            4'b0001: crc_match = (crc_next1 == CRC_RESIDUE);
            4'b0011: crc_match = (crc_next2 == CRC_RESIDUE);
            4'b0111: crc_match = (crc_next3 == CRC_RESIDUE);
            4'b1111: crc_match = (crc_next4 == CRC_RESIDUE);
            default: crc_match = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        in_ready_next = 1'b0;
        bad_fcs_next = 1'b0;
        crc_reset = 1'b0;
        crc_update = 1'b0;
        d0_load = 1'b0;
        d0_clear = 1'b0;
        tail_load = 1'b0;
        int_beat = d0_beat;
        int_beat.last = 1'b0;
        int_beat.user = 1'b0;
        int_valid = 1'b0;
        case (state)
            ST_IDLE: begin
                in_ready_next = int_ready_early;
                if (in_fire) begin
                    d0_load = 1'b1;
                    crc_update = 1'b1;
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                in_ready_next = int_ready_early;
                int_valid = d0_valid && in_fire;
                if (in_fire) begin
                    d0_load = 1'b1;
                    crc_update = 1'b1;
                    if (in_beat.last) begin
                        if (in_beat.keep[7:4] == 4'b0000) begin
                            // whole beat is fcs, held beat closes the frame
                            int_beat.keep = {in_beat.keep[3:0], 4'b1111};
                            int_beat.last = 1'b1;
                            int_beat.user = in_beat.user || !crc_match;
                            bad_fcs_next = !crc_match;
                            d0_load = 1'b0;
                            d0_clear = 1'b1;
                            crc_update = 1'b0;
                            crc_reset = 1'b1;
                            state_next = ST_IDLE;
                        end else begin
                            tail_load = 1'b1;
                            in_ready_next = 1'b0;
                            state_next = ST_TAIL;
                        end
                    end
                end
            end
            ST_TAIL: begin
                int_beat.keep = tail_keep;
                int_beat.last = 1'b1;
                int_beat.user = tail_user || !crc_match;
                int_valid = d0_valid;
                if (int_ready) begin
                    bad_fcs_next = !crc_match;
                    d0_clear = 1'b1;
                    crc_reset = 1'b1;
                    in_ready_next = int_ready_early;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            in_ready <= 1'b0;
            busy <= 1'b0;
            bad_fcs <= 1'b0;
            d0_valid <= 1'b0;
            crc_state <= CRC_INIT;
            crc_state4 <= CRC_INIT;
        end else begin
            state <= state_next;
            in_ready <= in_ready_next;
            busy <= (state_next != ST_IDLE);
            bad_fcs <= bad_fcs_next;
            if (crc_reset) begin
                crc_state <= CRC_INIT;
                crc_state4 <= CRC_INIT;
            end else if (crc_update) begin
                crc_state <= crc_next8;
                crc_state4 <= crc_next4;
            end
            if (d0_clear) begin
                d0_valid <= 1'b0;
            end else if (d0_load) begin
                d0_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (d0_load) begin
            d0_beat <= in_beat;
        end
        // bytes left over once the fcs is cut from the last beat
        if (tail_load) begin
            tail_keep <= {4'b0000, in_beat.keep[7:4]};
            tail_user <= in_beat.user;
        end
    end

endmodule

// ==== logic/fcs_frame_counter.sv ====
`timescale 1ns/1ps

module fcs_frame_counter #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     out_fire,
    input  logic                     out_last,
    input  logic                     out_user,
    output eth_fcs_pkg::fcs_status_t status
);
    import eth_fcs_pkg::*;

    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

    logic [COUNT_WIDTH-1:0] frame_cnt;
    logic [COUNT_WIDTH-1:0] bad_cnt;
    logic                   frame_end;

    assign frame_end = out_fire && out_last;

    // both counts stick at full scale
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_cnt <= '0;
            bad_cnt <= '0;
        end else begin
            if (frame_end && (frame_cnt != COUNT_MAX)) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (frame_end && out_user && (bad_cnt != COUNT_MAX)) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

    assign status.frame_count = STATUS_COUNT_W'(frame_cnt);
    assign status.bad_fcs_count = STATUS_COUNT_W'(bad_cnt);

endmodule

// ==== logic/eth_fcs_check.sv ====
`timescale 1ns/1ps

module eth_fcs_check #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_fcs_pkg::axis_beat_t  in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output eth_fcs_pkg::axis_beat_t  out_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     busy,
    output logic                     bad_fcs,
    output eth_fcs_pkg::fcs_status_t status
);
    import eth_fcs_pkg::*;

    axis_beat_t int_beat;
    logic       int_valid;
    logic       int_ready;
    logic       int_ready_early;
    logic       out_fire;

    assign out_fire = out_valid && out_ready;

    fcs_check_core u_core (
        .clk             (clk),
        .rst             (rst),
        .in_beat         (in_beat),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .int_beat        (int_beat),
        .int_valid       (int_valid),
        .int_ready       (int_ready),
        .int_ready_early (int_ready_early),
        .busy            (busy),
        .bad_fcs         (bad_fcs)
    );

    axis_skid_buffer u_skid (
        .clk             (clk),
        .rst             (rst),
        .int_beat        (int_beat),
        .int_valid       (int_valid),
        .int_ready       (int_ready),
        .int_ready_early (int_ready_early),
        .out_beat        (out_beat),
        .out_valid       (out_valid),
        .out_ready       (out_ready)
    );

    // counts what the sink actually takes
    fcs_frame_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_counter (
        .clk      (clk),
        .rst      (rst),
        .out_fire (out_fire),
        .out_last (out_beat.last),
        .out_user (out_beat.user),
        .status   (status)
    );

endmodule

// ==== verif/eth_fcs_check_chk.sv ====
`timescale 1ns/1ps

module eth_fcs_check_chk (
    input logic                    clk,
    input logic                    rst,
    input eth_fcs_pkg::axis_beat_t out_beat,
    input logic                    out_valid,
    input logic                    out_ready,
    input logic                    in_ready,
    input logic                    bad_fcs
);

    // a held output beat stays put until the sink takes it
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("out_beat changed or dropped while stalled");

    a_bad_pulse: assert property (@(posedge clk) disable iff (rst)
        bad_fcs |=> !bad_fcs)
        else $error("bad_fcs high for more than one cycle");

    a_ready_reset: assert property (@(posedge clk) rst |=> !in_ready)
        else $error("in_ready high right after reset");

endmodule

bind eth_fcs_check eth_fcs_check_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .bad_fcs   (bad_fcs)
);

// ==== verif/eth_fcs_check_tb.sv ====
`timescale 1ns/1ps

module eth_fcs_check_tb;
    import eth_fcs_pkg::*;

    localparam int COUNT_WIDTH = 16;
    localparam int N_ROWS = 12;

    // len counts the fcs, stall is the percent of cycles the sink holds off
    typedef struct packed {
        logic [7:0] len;
        logic       corrupt;
        logic       user;
        logic [7:0] stall;
    } row_t;

    localparam row_t ROWS [N_ROWS] = '{
        '{8'd9,  1'b0, 1'b0, 8'd0},
        '{8'd10, 1'b0, 1'b0, 8'd30},
        '{8'd11, 1'b0, 1'b0, 8'd0},
        '{8'd12, 1'b0, 1'b0, 8'd50},
        '{8'd13, 1'b0, 1'b0, 8'd0},
        '{8'd14, 1'b0, 1'b0, 8'd30},
        '{8'd15, 1'b0, 1'b0, 8'd0},
        '{8'd16, 1'b0, 1'b0, 8'd50},
        '{8'd64, 1'b1, 1'b0, 8'd30},
        '{8'd28, 1'b1, 1'b0, 8'd0},
        '{8'd37, 1'b0, 1'b1, 8'd50},
        '{8'd70, 1'b1, 1'b1, 8'd40}
    };

    logic        clk;
    logic        rst;
    axis_beat_t  in_beat;
    logic        in_valid;
    logic        in_ready;
    axis_beat_t  out_beat;
    logic        out_valid;
    logic        out_ready;
    logic        busy;
    logic        bad_fcs;
    fcs_status_t status;

    int          seed = 18;
    int          stall_pct = 0;
    int          beat_errors = 0;
    int          status_errors = 0;
    int          bad_pulses = 0;
    logic [7:0]  frame_bytes [0:127];
    axis_beat_t  exp_q [$];

    eth_fcs_check #(.COUNT_WIDTH(COUNT_WIDTH)) u_eth_fcs_check (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // bytewise reflected crc-32
    function automatic crc_t crc_byte(input crc_t crc_in, input logic [7:0] d);
        crc_t c;
        c = crc_in ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    // frame bytes start..stop-1, at most one beat, unused lanes zero
    function automatic axis_beat_t pack_beat(input int start, input int stop);
        axis_beat_t b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            if (start + k < stop) begin
                b.data[k*8 +: 8] = frame_bytes[start + k];
                b.keep[k] = 1'b1;
            end
        end
        b.last = (start + 8 >= stop);
        return b;
    endfunction

    task automatic check_beat(input axis_beat_t act, input axis_beat_t exp);
        axis_beat_t seen;
        seen = act;
        for (int k = 0; k < 8; k++) begin
            if (!act.keep[k]) begin
                seen.data[k*8 +: 8] = 8'h00;
            end
        end
        if (seen !== exp) begin
            $display("** Error: out_beat got %h exp %h", seen, exp);
            beat_errors++;
        end
    endtask

    task automatic check_status(input fcs_status_t act, input fcs_status_t exp);
        if (act !== exp) begin
            $display("** Error: status got %h exp %h", act, exp);
            status_errors++;
        end
    endtask

    task automatic check_count(input string name, input int act, input int exp);
        if (act != exp) begin
            $display("** Error: %s got %h exp %h", name, act, exp);
            status_errors++;
        end
    endtask

    task automatic send_beat(input axis_beat_t beat);
        logic taken;
        in_beat = beat;
        in_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && bad_fcs) begin
            bad_pulses++;
        end
    end

    // a beat seen valid and ready here transfers on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat arrived with no frame expected");
                beat_errors++;
            end else begin
                check_beat(out_beat, exp_q.pop_front());
            end
        end
    end

    initial begin
        out_ready = 1'b0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #1 out_ready = ($unsigned($random(seed)) % 100) >= stall_pct;
        end
    end

    initial begin
        int total;
        int limit;
        total = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += int'(ROWS[r].len);
        end
        limit = (total / 8) * 4 + 30 * N_ROWS + 100;
        repeat (limit) @(posedge clk);
        $display("timeout: test did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        fcs_status_t exp_status;
        crc_t        crc;
        int          len;
        int          n_bad;
        int          n_flagged;
        rst = 1'b1;
        in_valid = 1'b0;
        in_beat = '0;
        n_bad = 0;
        n_flagged = 0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        for (int r = 0; r < N_ROWS; r++) begin
            len = int'(ROWS[r].len);
            stall_pct = int'(ROWS[r].stall);
            crc = CRC_INIT;
            for (int i = 0; i < len - 4; i++) begin
                frame_bytes[i] = 8'($random(seed));
                crc = crc_byte(crc, frame_bytes[i]);
            end
            crc = ~crc;
            if (ROWS[r].corrupt) begin
                crc = crc ^ (32'h1 << ($unsigned($random(seed)) % 32));
                n_bad++;
            end
            // input-flagged frames also leave with user set
            if (ROWS[r].corrupt || ROWS[r].user) begin
                n_flagged++;
            end
            for (int k = 0; k < 4; k++) begin
                frame_bytes[len - 4 + k] = crc[k*8 +: 8];
            end
            for (int s = 0; s < len - 4; s += 8) begin
                exp_q.push_back(pack_beat(s, len - 4));
            end
            exp_q[exp_q.size() - 1].user = ROWS[r].user || ROWS[r].corrupt;
            // in_valid stays high from one frame into the next
            for (int s = 0; s < len; s += 8) begin
                in_beat = pack_beat(s, len);
                in_beat.user = in_beat.last && ROWS[r].user;
                send_beat(in_beat);
            end
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        exp_status.frame_count = STATUS_COUNT_W'(N_ROWS);
        exp_status.bad_fcs_count = STATUS_COUNT_W'(n_flagged);
        check_status(status, exp_status);
        check_count("bad_fcs pulses", bad_pulses, n_bad);
        check_count("busy", int'(busy), 0);
        $display("errors: beat %0d, status %0d", beat_errors, status_errors);
        if (beat_errors == 0 && status_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== eth_fcs_check.f ====
logic/eth_fcs_pkg.sv
logic/crc32_step.sv
logic/axis_skid_buffer.sv
logic/fcs_check_core.sv
logic/fcs_frame_counter.sv
logic/eth_fcs_check.sv
verif/eth_fcs_check_chk.sv
verif/eth_fcs_check_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then scan the log for a failing result
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module eth_fcs_check_tb \
    -f eth_fcs_check.f -o eth_fcs_check_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/eth_fcs_check_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
